//--- filelist.f
rtl/instrPkg.sv
rtl/hazardPkg.sv
rtl/instrDecode.sv
rtl/atCal.sv
rtl/stageTracker.sv
rtl/stallCtrl.sv
rtl/hazardUnit.sv
verif/hazardUnitTb.sv

//--- rtl/atCal.sv
`timescale 1ns/10ps

module atCal
(
	input  instrPkg::instrWord_u instr,
	output logic [instrPkg::REG_W-1:0] rAddr0,
	output logic [instrPkg::REG_W-1:0] rAddr1,
	output logic [instrPkg::REG_W-1:0] wAddr,
	output logic [hazardPkg::T_W-1:0] tuse0,
	output logic [hazardPkg::T_W-1:0] tuse1,
	output logic [hazardPkg::T_W-1:0] tnew
);

	logic [instrPkg::CLASS_W-1:0] cls;
	logic [instrPkg::REG_W-1:0] rs;
	logic [instrPkg::REG_W-1:0] rt;
	logic [instrPkg::REG_W-1:0] rd;

	instrDecode instrDecode_inst
	(
		.instr (instr),
		.cls   (cls),
		.rs    (rs),
		.rt    (rt),
		.rd    (rd)
	);

	//////////////////////////////////////////////////
	// Class table: reads, Tuse, write, Tnew
	//////////////////////////////////////////////////
	always_comb
	begin
		// Nothing read, nothing written
		rAddr0 = '0;
		rAddr1 = '0;
		tuse0 = hazardPkg::TUSE_NEVER;
		tuse1 = hazardPkg::TUSE_NEVER;
		wAddr = '0;
		tnew = '0;
		case (cls)
			instrPkg::CLS_R:
			begin
				rAddr0 = rs; tuse0 = 3'd1;
				rAddr1 = rt; tuse1 = 3'd1;
				wAddr = rd;  tnew = 3'd2;                 // ALU result after EX
			end
			instrPkg::CLS_I:
			begin
				rAddr0 = rs; tuse0 = 3'd1;
				wAddr = rt;  tnew = 3'd2;
			end
			instrPkg::CLS_LOAD:
			begin
				rAddr0 = rs; tuse0 = 3'd1;                // Base for address add
				wAddr = rt;  tnew = 3'd3;                 // Data out of MEM
			end
			instrPkg::CLS_STORE:
			begin
				rAddr0 = rs; tuse0 = 3'd1;
				rAddr1 = rt; tuse1 = 3'd2;                // Store data needed in MEM
			end
			instrPkg::CLS_BR1, instrPkg::CLS_JR:
			begin
				rAddr0 = rs; tuse0 = 3'd0;                // Compared in ID
			end
			instrPkg::CLS_BR2:
			begin
				rAddr0 = rs; tuse0 = 3'd0;
				rAddr1 = rt; tuse1 = 3'd0;
			end
			instrPkg::CLS_LUI:
			begin
				wAddr = rt;  tnew = 3'd1;
			end
			instrPkg::CLS_JAL:
			begin
				wAddr = instrPkg::REG_RA;                 // Link into $31
				tnew = 3'd1;                              // PC+8 ready from ID
			end
			instrPkg::CLS_JALR:
			begin
				rAddr0 = rs; tuse0 = 3'd0;
				wAddr = rd;  tnew = 3'd1;
			end
			instrPkg::CLS_MTHL:
			begin
				rAddr0 = rs; tuse0 = 3'd1;                // HI/LO written in EX
			end
			instrPkg::CLS_MULDIV:
			begin
				rAddr0 = rs; tuse0 = 3'd1;
				rAddr1 = rt; tuse1 = 3'd1;
			end
			instrPkg::CLS_MFHL:
			begin
				wAddr = rd;  tnew = 3'd2;                 // HI/LO read out in EX
			end
			instrPkg::CLS_MFC0:
			begin
				rAddr1 = rd; tuse1 = 3'd2;                // CP0 index used in MEM
				wAddr = rt;  tnew = 3'd3;
			end
			instrPkg::CLS_MTC0:
			begin
				rAddr0 = rt; tuse0 = 3'd1;                // Only EX has a forward path
				rAddr1 = rd; tuse1 = 3'd2;
			end
			default:
			begin
				// nop and j keep the defaults
				rAddr0 = '0;
			end
		endcase
	end

	// A real destination always comes with a result still to produce
	always_comb
	begin
		assert final ((wAddr == '0 || tnew != '0) && tnew <= hazardPkg::TNEW_MAX)
			else $error("atCal: wAddr %0d with tnew %0d", wAddr, tnew);
	end

endmodule

//--- rtl/hazardPkg.sv
package hazardPkg;

	//////////////////////////////////////////////////
	// Tuse / Tnew timing
	//////////////////////////////////////////////////
	localparam int T_W = 3;                          // Stage count width

	// Operand not read at all, larger than any Tnew
	localparam logic [T_W-1:0] TUSE_NEVER = 3'd7;

	// Latest result of any class, load and mfc0 give 3
	localparam logic [T_W-1:0] TNEW_MAX = 3'd3;

	//////////////////////////////////////////////////
	// Forward select codes
	//////////////////////////////////////////////////
	localparam int FWD_W = 2;

	localparam logic [FWD_W-1:0] FWD_RF  = 2'd0;     // Register file value
	localparam logic [FWD_W-1:0] FWD_EX  = 2'd1;     // EX stage result
	localparam logic [FWD_W-1:0] FWD_MEM = 2'd2;     // MEM stage result
	localparam logic [FWD_W-1:0] FWD_WB  = 2'd3;     // WB stage result

endpackage

//--- rtl/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit
(
	input  logic clk,
	input  logic reset,
	input  instrPkg::instrWord_u instr,
	output logic stall,
	output logic [hazardPkg::FWD_W-1:0] fwd0,
	output logic [hazardPkg::FWD_W-1:0] fwd1
);

	// ID demand
	logic [instrPkg::REG_W-1:0] rAddr0, rAddr1, wAddr;
	logic [hazardPkg::T_W-1:0] tuse0, tuse1, tnew;
	// In-flight supply
	logic [instrPkg::REG_W-1:0] exAddr, memAddr, wbAddr;
	logic [hazardPkg::T_W-1:0] exTnew, memTnew, wbTnew;

	atCal atCal_inst
	(
		.instr  (instr),
		.rAddr0 (rAddr0),
		.rAddr1 (rAddr1),
		.wAddr  (wAddr),
		.tuse0  (tuse0),
		.tuse1  (tuse1),
		.tnew   (tnew)
	);

	stageTracker stageTracker_inst
	(
		.clk     (clk),
		.reset   (reset),
		.stall   (stall),           // Bubble into EX
		.wAddr   (wAddr),
		.tnew    (tnew),
		.exAddr  (exAddr),
		.memAddr (memAddr),
		.wbAddr  (wbAddr),
		.exTnew  (exTnew),
		.memTnew (memTnew),
		.wbTnew  (wbTnew)
	);

	stallCtrl stallCtrl_inst
	(
		.rAddr0  (rAddr0),
		.rAddr1  (rAddr1),
		.tuse0   (tuse0),
		.tuse1   (tuse1),
		.exAddr  (exAddr),
		.memAddr (memAddr),
		.wbAddr  (wbAddr),
		.exTnew  (exTnew),
		.memTnew (memTnew),
		.wbTnew  (wbTnew),
		.stall   (stall),
		.fwd0    (fwd0),
		.fwd1    (fwd1)
	);

endmodule

//--- rtl/instrDecode.sv
`timescale 1ns/10ps

module instrDecode
(
	input  instrPkg::instrWord_u instr,
	output logic [instrPkg::CLASS_W-1:0] cls,
	output logic [instrPkg::REG_W-1:0] rs,
	output logic [instrPkg::REG_W-1:0] rt,
	output logic [instrPkg::REG_W-1:0] rd
);

	// Register fields sit at the same place in both views
	assign rs = instr.r.rs;
	assign rt = instr.i.rt;
	assign rd = instr.r.rd;

	always_comb
	begin
		cls = instrPkg::CLS_NOP;                      // Unknown word acts as a bubble
		if (instr.r.op == instrPkg::OP_SPECIAL)
		begin
			// SPECIAL decodes on funct
			case (instr.r.funct)
				instrPkg::FN_ADDU, instrPkg::FN_SUBU, instrPkg::FN_ADD, instrPkg::FN_SUB,
				instrPkg::FN_AND, instrPkg::FN_OR, instrPkg::FN_XOR, instrPkg::FN_NOR,
				instrPkg::FN_SLT, instrPkg::FN_SLTU,
				instrPkg::FN_SLL, instrPkg::FN_SRL, instrPkg::FN_SRA,
				instrPkg::FN_SLLV, instrPkg::FN_SRLV, instrPkg::FN_SRAV:
					cls = instrPkg::CLS_R;
				instrPkg::FN_JR:   cls = instrPkg::CLS_JR;
				instrPkg::FN_JALR: cls = instrPkg::CLS_JALR;
				instrPkg::FN_MTHI, instrPkg::FN_MTLO:
					cls = instrPkg::CLS_MTHL;               // Write HI/LO from rs
				instrPkg::FN_MULT, instrPkg::FN_MULTU, instrPkg::FN_DIV, instrPkg::FN_DIVU:
					cls = instrPkg::CLS_MULDIV;
				instrPkg::FN_MFHI, instrPkg::FN_MFLO:
					cls = instrPkg::CLS_MFHL;               // Result into rd
				default: cls = instrPkg::CLS_NOP;
			endcase
		end
		else if (instr.r.op == instrPkg::OP_COP0)
		begin
			// COP0 sub-op in rs
			case (instr.r.rs)
				instrPkg::CP0_MF: cls = instrPkg::CLS_MFC0;
				instrPkg::CP0_MT: cls = instrPkg::CLS_MTC0;
				default:          cls = instrPkg::CLS_NOP;
			endcase
		end
		else
		begin
			case (instr.i.op)
				instrPkg::OP_ORI, instrPkg::OP_ADDIU, instrPkg::OP_ADDI, instrPkg::OP_ANDI,
				instrPkg::OP_XORI, instrPkg::OP_SLTI, instrPkg::OP_SLTIU:
					cls = instrPkg::CLS_I;
				instrPkg::OP_LW, instrPkg::OP_LB, instrPkg::OP_LBU,
				instrPkg::OP_LH, instrPkg::OP_LHU:
					cls = instrPkg::CLS_LOAD;
				instrPkg::OP_SW, instrPkg::OP_SH, instrPkg::OP_SB:
					cls = instrPkg::CLS_STORE;
				instrPkg::OP_BEQ, instrPkg::OP_BNE:
					cls = instrPkg::CLS_BR2;
				instrPkg::OP_BGTZ, instrPkg::OP_BLEZ:
					cls = instrPkg::CLS_BR1;
				instrPkg::OP_REGIMM:
				begin
					// Only bltz/bgez, other rt codes fall to nop
					if (instr.i.rt == instrPkg::RT_BLTZ || instr.i.rt == instrPkg::RT_BGEZ)
						cls = instrPkg::CLS_BR1;
					else
						cls = instrPkg::CLS_NOP;
				end
				instrPkg::OP_LUI: cls = instrPkg::CLS_LUI;
				instrPkg::OP_JAL: cls = instrPkg::CLS_JAL;
				instrPkg::OP_J:   cls = instrPkg::CLS_J;
				default:          cls = instrPkg::CLS_NOP;
			endcase
		end
	end

endmodule

//--- rtl/instrPkg.sv
package instrPkg;

	//////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////
	localparam int REG_W = 5;                       // GPR address width
	localparam int CLASS_W = 4;                     // Class code width
	localparam logic [REG_W-1:0] REG_RA = 5'd31;   // Link register for jal

	// Primary opcodes, bits 31:26
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;      // bgez/bltz, decoded on rt
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_COP0    = 6'h10;      // Sub-op lives in rs
	localparam logic [5:0] OP_LB      = 6'h20;
	localparam logic [5:0] OP_LH      = 6'h21;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_LHU     = 6'h25;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SH      = 6'h29;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL function codes, bits 5:0
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_SRL   = 6'h02;
	localparam logic [5:0] FN_SRA   = 6'h03;
	localparam logic [5:0] FN_SLLV  = 6'h04;
	localparam logic [5:0] FN_SRLV  = 6'h06;
	localparam logic [5:0] FN_SRAV  = 6'h07;
	localparam logic [5:0] FN_JR    = 6'h08;
	localparam logic [5:0] FN_JALR  = 6'h09;
	localparam logic [5:0] FN_MFHI  = 6'h10;
	localparam logic [5:0] FN_MTHI  = 6'h11;
	localparam logic [5:0] FN_MFLO  = 6'h12;
	localparam logic [5:0] FN_MTLO  = 6'h13;
	localparam logic [5:0] FN_MULT  = 6'h18;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_DIV   = 6'h1a;
	localparam logic [5:0] FN_DIVU  = 6'h1b;
	localparam logic [5:0] FN_ADD   = 6'h20;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUB   = 6'h22;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_NOR   = 6'h27;
	localparam logic [5:0] FN_SLT   = 6'h2a;
	localparam logic [5:0] FN_SLTU  = 6'h2b;

	// REGIMM rt codes and COP0 rs codes
	localparam logic [REG_W-1:0] RT_BLTZ = 5'd0;
	localparam logic [REG_W-1:0] RT_BGEZ = 5'd1;
	localparam logic [REG_W-1:0] CP0_MF  = 5'd0;
	localparam logic [REG_W-1:0] CP0_MT  = 5'd4;

	//////////////////////////////////////////////////
	// Instruction classes, one per timing group
	//////////////////////////////////////////////////
	localparam logic [CLASS_W-1:0] CLS_NOP    = 4'd0;
	localparam logic [CLASS_W-1:0] CLS_J      = CLS_NOP;   // j touches no GPR, bubble timing
	localparam logic [CLASS_W-1:0] CLS_R      = 4'd1;
	localparam logic [CLASS_W-1:0] CLS_I      = 4'd2;
	localparam logic [CLASS_W-1:0] CLS_LOAD   = 4'd3;
	localparam logic [CLASS_W-1:0] CLS_STORE  = 4'd4;
	localparam logic [CLASS_W-1:0] CLS_BR1    = 4'd5;      // rs only
	localparam logic [CLASS_W-1:0] CLS_BR2    = 4'd6;      // rs and rt
	localparam logic [CLASS_W-1:0] CLS_LUI    = 4'd7;
	localparam logic [CLASS_W-1:0] CLS_JAL    = 4'd8;
	localparam logic [CLASS_W-1:0] CLS_JR     = 4'd9;
	localparam logic [CLASS_W-1:0] CLS_JALR   = 4'd10;
	localparam logic [CLASS_W-1:0] CLS_MTHL   = 4'd11;
	localparam logic [CLASS_W-1:0] CLS_MULDIV = 4'd12;
	localparam logic [CLASS_W-1:0] CLS_MFHL   = 4'd13;
	localparam logic [CLASS_W-1:0] CLS_MFC0   = 4'd14;
	localparam logic [CLASS_W-1:0] CLS_MTC0   = 4'd15;

	// Two views of one instruction word
	typedef struct packed
	{
		logic [5:0] op;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [REG_W-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_s;

	typedef struct packed
	{
		logic [5:0] op;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [15:0] imm;
	} iFields_s;

	typedef union packed
	{
		rFields_s r;
		iFields_s i;
	} instrWord_u;

endpackage

//--- rtl/stageTracker.sv
`timescale 1ns/10ps

module stageTracker
(
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic [instrPkg::REG_W-1:0] wAddr,
	input  logic [hazardPkg::T_W-1:0] tnew,
	output logic [instrPkg::REG_W-1:0] exAddr,
	output logic [instrPkg::REG_W-1:0] memAddr,
	output logic [instrPkg::REG_W-1:0] wbAddr,
	output logic [hazardPkg::T_W-1:0] exTnew,
	output logic [hazardPkg::T_W-1:0] memTnew,
	output logic [hazardPkg::T_W-1:0] wbTnew
);

	// One stage closer to the result, floored at zero
	function automatic logic [hazardPkg::T_W-1:0] ageT(input logic [hazardPkg::T_W-1:0] t);
		ageT = (t == '0) ? '0 : t - 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// In-flight slots EX -> MEM -> WB
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exAddr <= '0;
			exTnew <= '0;
			memAddr <= '0;
			memTnew <= '0;
			wbAddr <= '0;
			wbTnew <= '0;
		end
		else
		begin
			if (stall)
			begin
				exAddr <= '0;                             // Bubble into EX
				exTnew <= '0;
			end
			else
			begin
				exAddr <= wAddr;                          // ID instruction moves on
				exTnew <= ageT(tnew);
			end
			memAddr <= exAddr;                            // Later stages never hold
			memTnew <= ageT(exTnew);
			wbAddr <= memAddr;
			wbTnew <= ageT(memTnew);
		end
	end

	// Tnew of 3 at most means every result exists by WB
	assert property (@(posedge clk) !reset |=> (wbTnew == '0))
		else $error("stageTracker: result still pending in WB, tnew %0d", wbTnew);

endmodule

//--- rtl/stallCtrl.sv
`timescale 1ns/10ps

module stallCtrl
(
	input  logic [instrPkg::REG_W-1:0] rAddr0,
	input  logic [instrPkg::REG_W-1:0] rAddr1,
	input  logic [hazardPkg::T_W-1:0] tuse0,
	input  logic [hazardPkg::T_W-1:0] tuse1,
	input  logic [instrPkg::REG_W-1:0] exAddr,
	input  logic [instrPkg::REG_W-1:0] memAddr,
	input  logic [instrPkg::REG_W-1:0] wbAddr,
	input  logic [hazardPkg::T_W-1:0] exTnew,
	input  logic [hazardPkg::T_W-1:0] memTnew,
	input  logic [hazardPkg::T_W-1:0] wbTnew,
	output logic stall,
	output logic [hazardPkg::FWD_W-1:0] fwd0,
	output logic [hazardPkg::FWD_W-1:0] fwd1
);

	logic [instrPkg::REG_W-1:0] rAddrArr [2];
	logic [hazardPkg::T_W-1:0] tuseArr [2];
	logic [hazardPkg::FWD_W-1:0] fwdArr [2];
	logic [1:0] portStall;

	assign rAddrArr[0] = rAddr0;
	assign rAddrArr[1] = rAddr1;
	assign tuseArr[0] = tuse0;
	assign tuseArr[1] = tuse1;

	//////////////////////////////////////////////////
	// Per-port nearest match
	//////////////////////////////////////////////////
	for (genvar p = 0; p < 2; p++)
	begin : portGen
		logic found;
		logic [hazardPkg::T_W-1:0] hitTnew;
		logic [hazardPkg::FWD_W-1:0] hitSrc;

		always_comb
		begin
			found = 1'b1;
			if (rAddrArr[p] == '0)                        // $0 is never a hazard
			begin
				found = 1'b0;
				hitSrc = hazardPkg::FWD_RF;
				hitTnew = '0;
			end
			else if (rAddrArr[p] == exAddr)               // Youngest producer first
			begin
				hitSrc = hazardPkg::FWD_EX;
				hitTnew = exTnew;
			end
			else if (rAddrArr[p] == memAddr)
			begin
				hitSrc = hazardPkg::FWD_MEM;
				hitTnew = memTnew;
			end
			else if (rAddrArr[p] == wbAddr)
			begin
				hitSrc = hazardPkg::FWD_WB;
				hitTnew = wbTnew;
			end
			else
			begin
				found = 1'b0;                             // Register file is current
				hitSrc = hazardPkg::FWD_RF;
				hitTnew = '0;
			end
		end

		// Result later than the port can wait
		assign portStall[p] = found && (hitTnew > tuseArr[p]);
		// Forward only a finished result, else read RF now
		assign fwdArr[p] = (found && hitTnew == '0) ? hitSrc : hazardPkg::FWD_RF;
	end

	assign stall = |portStall;
	assign fwd0 = fwdArr[0];
	assign fwd1 = fwdArr[1];

endmodule

//--- verif/hazardStimulus.txt
// Columns: instruction word, expected stall, expected fwd0, expected fwd1 (0 RF, 1 EX, 2 MEM, 3 WB)
// One row per cycle after reset; a stalled word is repeated in the next row
00000000 0 0 0 // idle after reset
00000000 0 0 0
00222821 0 0 0 // addu $5,$1,$2
00A33021 0 0 0 // addu $6,$5,$3, producer in EX with tnew 1
00A63825 0 2 0 // or $7,$5,$6
00A65024 0 3 2 // and $10,$5,$6
00000000 0 0 0
00000000 0 0 0
00000000 0 0 0
8C280000 0 0 0 // lw $8,0($1)
11020004 1 0 0 // beq $8,$2 waits on load
11020004 1 0 0
11020004 0 3 0
342B00FF 0 0 0 // ori $11,$1,0xff
15600004 1 0 0 // bne $11,$0
15600004 0 2 0
8C490004 0 0 0 // lw $9,4($2)
AC690008 0 0 0 // sw $9, data needed in MEM
A069000C 0 0 0 // sb $9
A4690010 0 0 3 // sh $9
242C0001 0 0 0 // addiu $12,$1,1
244C0002 0 0 0 // addiu $12,$2,2
00000000 0 0 0
01806826 0 2 0 // xor $13,$12,$0, younger write wins
8C200000 0 0 0 // lw $0,0($1)
10000004 0 0 0 // beq $0,$0 never stalls
0C000010 0 0 0 // jal
03E00008 0 1 0 // jr $31
400E6000 0 0 0 // mfc0 $14,$12
01CE7821 1 0 0 // addu $15,$14,$14
01CE7821 0 0 0
408F7000 0 0 3 // mtc0 $15,$14
00008012 0 0 0 // mflo $16
00008810 0 0 0 // mfhi $17
02110018 0 2 0 // mult $16,$17
02200011 0 2 0 // mthi $17
02200013 0 3 0 // mtlo $17
08000020 0 0 0 // j
FFFFFFFF 0 0 0 // unknown opcode
00000000 0 0 0

//--- verif/hazardUnitTb.sv
`timescale 1ns/10ps

module hazardUnitTb;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_ROWS = 64;
	localparam int ROW_WORDS = 4;                      // instr, stall, fwd0, fwd1
	localparam int SLACK_CYCLES = 20;

	logic clk;
	logic reset;
	instrPkg::instrWord_u instr;
	logic stall;
	logic [hazardPkg::FWD_W-1:0] fwd0;
	logic [hazardPkg::FWD_W-1:0] fwd1;

	// Flat image of the stimulus file, four words per row
	logic [31:0] stimMem [0:MAX_ROWS*ROW_WORDS-1];
	int rowCount;
	int curRow;
	int cycleCount = 0;
	int cycleLimit = RESET_CYCLES + MAX_ROWS + SLACK_CYCLES;
	int stallErrors;
	int fwdErrors;

	hazardUnit hazardUnit_inst
	(
		.clk   (clk),
		.reset (reset),
		.instr (instr),
		.stall (stall),
		.fwd0  (fwd0),
		.fwd1  (fwd1)
	);

	// 100 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkStall(input logic expStall);
		if (stall !== expStall)
		begin
			stallErrors++;
			$display("ERR %0t: row %0d stall %b, expected %b", $time, curRow, stall, expStall);
		end
	endtask

	task automatic checkFwd(input logic [hazardPkg::FWD_W-1:0] expFwd, input int port);
		logic [hazardPkg::FWD_W-1:0] got;
		got = (port == 0) ? fwd0 : fwd1;            // Pick the port under test
		if (got !== expFwd)
		begin
			fwdErrors++;
			$display("ERR %0t: row %0d fwd%0d is %0d, expected %0d",
				$time, curRow, port, got, expFwd);
		end
	endtask

	// Watchdog on rising edges
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles, stimulus did not finish", cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Reset phase and row playback
	//////////////////////////////////////////////////
	task automatic applyReset();
		// Held for 16 edges, released on the last one
		for (int c = 0; c < RESET_CYCLES; c++)
		begin
			@(posedge clk);
			if (c == RESET_CYCLES - 1)
				reset <= 1'b0;
			@(negedge clk);
			checkStall(1'b0);                        // Idle outputs while in reset
			checkFwd(hazardPkg::FWD_RF, 0);
			checkFwd(hazardPkg::FWD_RF, 1);
		end
	endtask

	task automatic playRows();
		int base;
		for (int r = 0; r < rowCount; r++)
		begin
			base = r * ROW_WORDS;
			@(posedge clk);
			curRow = r;
			instr <= stimMem[base];                     // New ID word on the edge
			@(negedge clk);
			// Slots and combinational outputs settled by now
			checkStall(stimMem[base + 1][0]);
			checkFwd(stimMem[base + 2][hazardPkg::FWD_W-1:0], 0);
			checkFwd(stimMem[base + 3][hazardPkg::FWD_W-1:0], 1);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		instr = '0;
		stallErrors = 0;
		fwdErrors = 0;
		curRow = -1;
		for (int i = 0; i < MAX_ROWS * ROW_WORDS; i++)
			stimMem[i] = 'x;                            // Unloaded rows stay unknown
		$readmemh("verif/hazardStimulus.txt", stimMem);

		// Rows end at the first unknown instruction word
		rowCount = 0;
		while (rowCount < MAX_ROWS && !$isunknown(stimMem[rowCount * ROW_WORDS]))
			rowCount++;

		if (rowCount == 0)
		begin
			$display("Stimulus file verif/hazardStimulus.txt is missing or has no rows");
			$display("Test failed");
			$finish;
		end
		else
		begin
			cycleLimit = RESET_CYCLES + rowCount + SLACK_CYCLES;
			applyReset();
			playRows();
			$display("Errors: stall %0d, forward %0d, total %0d",
				stallErrors, fwdErrors, stallErrors + fwdErrors);
			if (stallErrors + fwdErrors == 0)
				$display("Test passed");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule
